//--- design/addrTranslate.sv
`include "mem_config.svh"

module addrTranslate import memPkg::*; (
    input  word_t vaddr,
    output word_t paddr,
    output logic  uncached
);

    logic inKseg01;

    // 100 = kseg0, 101 = kseg1
    assign inKseg01 = (vaddr[31:30] == 2'b10);

    // unmapped segments drop their top bits, the rest pass through
    always_comb begin
        paddr = vaddr;
        if (inKseg01) begin
            paddr = {{`KSEG_MASK_BITS{1'b0}}, vaddr[31-`KSEG_MASK_BITS:0]};
        end
    end

    assign uncached = inKseg01 && vaddr[`UNCACHED_BIT];

endmodule

//--- design/excResolve.sv
`include "mem_config.svh"

module excResolve import memPkg::*; (
    input  exData_t    dataE[2],
    input  logic [1:0] storeMis,
    input  logic [1:0] loadMis,
    output exData_t    dataM[2],
    output logic [1:0] laneGo,
    output logic       excpM
);

    logic [1:0] memOp;
    logic [1:0] misHit;
    logic       squash;

    function automatic logic isTrap(ctype_e t);
        return t == EXCEPTION || t == ERET;
    endfunction

    // turn an address error into a cp0 exception
    function automatic exData_t markMis(exData_t d);
        exData_t r;
        r = d;
        r.cp0Ctl.valid    = 1'b1;
        r.cp0Ctl.ctype    = EXCEPTION;
        r.cp0Ctl.code     = d.ctl.memWrite ? `EXC_ADES : `EXC_ADEL;
        r.cp0Ctl.badVaddr = d.aluOut;
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            memOp[i]  = dataE[i].ctl.memWrite || dataE[i].ctl.memToReg;
            misHit[i] = dataE[i].valid &&
                ((dataE[i].ctl.memWrite && storeMis[i]) ||
                 (dataE[i].ctl.memToReg && loadMis[i]));
        end
    end

    // lane 1 is older, so it is resolved first and may kill lane 0
    always_comb begin
        dataM[1] = misHit[1] ? markMis(dataE[1]) : dataE[1];
        squash   = isTrap(dataM[1].cp0Ctl.ctype);
        dataM[0] = dataE[0];
        if (squash) begin
            dataM[0].ctl.regWrite = 1'b0;
            dataM[0].ctl.memToReg = 1'b0;
            dataM[0].ctl.loWrite  = 1'b0;
            dataM[0].ctl.hiWrite  = 1'b0;
            dataM[0].ctl.cp0Write = 1'b0;
            dataM[0].cp0Ctl.valid = 1'b0;
        end else if (misHit[0]) begin
            dataM[0] = markMis(dataE[0]);
        end
    end

    assign laneGo[1] = dataE[1].valid && memOp[1] && !isTrap(dataM[1].cp0Ctl.ctype);
    assign laneGo[0] = dataE[0].valid && memOp[0] && !isTrap(dataM[0].cp0Ctl.ctype)
                       && !squash;

    // interrupts count here too but block nothing on the bus
    assign excpM = (dataM[1].cp0Ctl.ctype != NOEVENT) || (dataM[0].cp0Ctl.ctype != NOEVENT);

endmodule

//--- design/loadExtract.sv
module loadExtract import memPkg::*; (
    input  logic [1:0] addrLow,
    input  msize_e     size,
    input  logic       isUnsigned,
    input  word_t      raw,
    output word_t      data,
    output logic       misaligned
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    always_comb begin
        case (addrLow)
            2'd0: byteSel = raw[7:0];
            2'd1: byteSel = raw[15:8];
            2'd2: byteSel = raw[23:16];
            default: byteSel = raw[31:24];
        endcase
    end

    assign halfSel = addrLow[1] ? raw[31:16] : raw[15:0];

    always_comb begin
        case (size)
            MSIZE1: begin
                data       = {{24{byteSel[7] & ~isUnsigned}}, byteSel};
                misaligned = 1'b0;
            end
            MSIZE2: begin
                data       = {{16{halfSel[15] & ~isUnsigned}}, halfSel};
                misaligned = addrLow[0];
            end
            default: begin
                data       = raw;
                misaligned = |addrLow;
            end
        endcase
    end

endmodule

//--- design/memAccessFsm.sv
module memAccessFsm import memPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic [1:0] laneGo,
    input  dbusReq_t   reqLane[2],
    input  dbusResp_t  dresp,
    output word_t      loadRaw[2],
    output dbusReq_t   dreq,
    output logic       stallM
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        LANE1 = 2'd1,
        LANE0 = 2'd2,
        DONE  = 2'd3
    } state_e;

    state_e state;
    state_e stateNext;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // older lane always goes out first
    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (laneGo[1]) begin
                    stateNext = LANE1;
                end else if (laneGo[0]) begin
                    stateNext = LANE0;
                end
            end
            LANE1: begin
                if (dresp.dataOk) begin
                    stateNext = laneGo[0] ? LANE0 : DONE;
                end
            end
            LANE0: begin
                if (dresp.dataOk) begin
                    stateNext = DONE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    // request held as a level until dataOk
    always_comb begin
        dreq = '0;
        if (state == LANE1) begin
            dreq       = reqLane[1];
            dreq.valid = 1'b1;
        end else if (state == LANE0) begin
            dreq       = reqLane[0];
            dreq.valid = 1'b1;
        end
    end

    // done drops the stall so upstream steps past this bundle
    assign stallM = (state == LANE1) || (state == LANE0) || (state == IDLE && |laneGo);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            loadRaw[0] <= '0;
            loadRaw[1] <= '0;
        end else if (dresp.dataOk) begin
            if (state == LANE1) begin
                loadRaw[1] <= dresp.data;
            end else if (state == LANE0) begin
                loadRaw[0] <= dresp.data;
            end
        end
    end

endmodule

//--- design/memPkg.sv
package memPkg;

    typedef logic [31:0] word_t;

    // access width, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,
        MSIZE2 = 2'd1,
        MSIZE4 = 2'd2
    } msize_e;

    // kind of cp0 event a lane carries
    typedef enum logic [1:0] {
        NOEVENT   = 2'd0,
        EXCEPTION = 2'd1,
        INTERRUPT = 2'd2,
        ERET      = 2'd3
    } ctype_e;

    // decoded control for one instruction
    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        logic   loWrite;
        logic   hiWrite;
        logic   cp0Write;
        logic   loadUnsigned;
        msize_e msize;
    } ctl_t;

    // what cp0 needs to know about this lane
    typedef struct packed {
        logic       valid;
        ctype_e     ctype;
        logic [4:0] code;
        word_t      badVaddr;
        // instruction sits in a branch delay slot
        logic       isSlot;
    } cp0Ctl_t;

    // execute result for one lane
    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [4:0] rdst;
        ctl_t       ctl;
        word_t      aluOut;
        word_t      srcb;
        cp0Ctl_t    cp0Ctl;
    } exData_t;

    // data bus request with the physical addr
    typedef struct packed {
        logic       valid;
        word_t      addr;
        logic       uncached;
        msize_e     size;
        logic [3:0] strobe;
        word_t      data;
    } dbusReq_t;

    // dataOk is a one-cycle pulse
    typedef struct packed {
        logic  dataOk;
        word_t data;
    } dbusResp_t;

endpackage

//--- design/memStage.sv
module memStage import memPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  exData_t   dataE[2],
    output exData_t   dataM[2],
    output word_t     loadData[2],
    output dbusReq_t  dreq,
    input  dbusResp_t dresp,
    output logic      stallM,
    output logic      excpM
);

    word_t      paddr[2];
    logic [1:0] uncached;
    word_t      wdata[2];
    logic [3:0] strobe[2];
    logic [1:0] storeMis;
    logic [1:0] loadMis;
    logic [1:0] laneGo;
    dbusReq_t   reqLane[2];
    word_t      loadRaw[2];

    for (genvar i = 0; i < 2; i++) begin : gLane
        addrTranslate uTrans (
            .vaddr    (dataE[i].aluOut),
            .paddr    (paddr[i]),
            .uncached (uncached[i])
        );

        storeAlign uStore (
            .addrLow    (dataE[i].aluOut[1:0]),
            .srcb       (dataE[i].srcb),
            .size       (dataE[i].ctl.msize),
            .wdata      (wdata[i]),
            .strobe     (strobe[i]),
            .misaligned (storeMis[i])
        );

        // raw is the word captured by the FSM for this lane
        loadExtract uLoad (
            .addrLow    (dataE[i].aluOut[1:0]),
            .size       (dataE[i].ctl.msize),
            .isUnsigned (dataE[i].ctl.loadUnsigned),
            .raw        (loadRaw[i]),
            .data       (loadData[i]),
            .misaligned (loadMis[i])
        );

        // loads go out with no strobe and no data
        always_comb begin
            reqLane[i]          = '0;
            reqLane[i].addr     = paddr[i];
            reqLane[i].uncached = uncached[i];
            reqLane[i].size     = dataE[i].ctl.msize;
            if (dataE[i].ctl.memWrite) begin
                reqLane[i].strobe = strobe[i];
                reqLane[i].data   = wdata[i];
            end
        end
    end

    excResolve uExc (
        .dataE    (dataE),
        .storeMis (storeMis),
        .loadMis  (loadMis),
        .dataM    (dataM),
        .laneGo   (laneGo),
        .excpM    (excpM)
    );

    memAccessFsm uFsm (
        .clk     (clk),
        .rstN    (rstN),
        .laneGo  (laneGo),
        .reqLane (reqLane),
        .dresp   (dresp),
        .loadRaw (loadRaw),
        .dreq    (dreq),
        .stallM  (stallM)
    );

endmodule

//--- design/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// kseg1 is kseg0 with this address bit set
`define UNCACHED_BIT 29

// top bits dropped when mapping kseg0/kseg1 to physical
`define KSEG_MASK_BITS 3

// cp0 cause codes for address errors
// load or fetch
`define EXC_ADEL 5'd4
// store
`define EXC_ADES 5'd5

`endif

//--- design/storeAlign.sv
module storeAlign import memPkg::*; (
    input  logic [1:0] addrLow,
    input  word_t      srcb,
    input  msize_e     size,
    output word_t      wdata,
    output logic [3:0] strobe,
    output logic       misaligned
);

    logic [3:0] rawStrobe;

    // data is replicated so the bus can pick any byte lane
    always_comb begin
        case (size)
            MSIZE1: begin
                wdata      = {4{srcb[7:0]}};
                rawStrobe  = 4'b0001 << addrLow;
                misaligned = 1'b0;
            end
            MSIZE2: begin
                wdata      = {2{srcb[15:0]}};
                rawStrobe  = addrLow[1] ? 4'b1100 : 4'b0011;
                misaligned = addrLow[0];
            end
            default: begin
                // word, and the unused encoding
                wdata      = srcb;
                rawStrobe  = 4'b1111;
                misaligned = |addrLow;
            end
        endcase
    end

    // a bad store must never touch memory
    assign strobe = misaligned ? 4'b0000 : rawStrobe;

endmodule

//--- project.f
+incdir+design
design/memPkg.sv
design/addrTranslate.sv
design/storeAlign.sv
design/loadExtract.sv
design/excResolve.sv
design/memAccessFsm.sv
design/memStage.sv
testbench/memStage_assert.sv
testbench/memStageTb.sv

//--- run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module memStageTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/VmemStageTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- testbench/memStageTb.sv
module memStageTb import memPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_BUNDLES  = 300;
    localparam int RESET_CYCLES = 10;
    // two accesses of at most five cycles each per bundle
    localparam int CYCLE_LIMIT  = NUM_BUNDLES * 2 * 5 + RESET_CYCLES;
    localparam word_t RESP_KEY  = 32'h5a3c96e1;

    logic      clk;
    logic      rstN;
    exData_t   dataE[2];
    exData_t   dataM[2];
    word_t     loadData[2];
    dbusReq_t  dreq;
    dbusResp_t dresp;
    logic      stallM;
    logic      excpM;
    logic      running;
    int        bundleCount;
    int        waitLeft;
    int        cycleCount = 0;

    memStage UUT (
        .clk      (clk),
        .rstN     (rstN),
        .dataE    (dataE),
        .dataM    (dataM),
        .loadData (loadData),
        .dreq     (dreq),
        .dresp    (dresp),
        .stallM   (stallM),
        .excpM    (excpM)
    );

    // one random lane with addresses over kuseg, kseg0 and kseg1
    function automatic exData_t randomLane();
        exData_t d;
        int op;
        int ev;
        d = '0;
        op = $urandom_range(2, 0);
        ev = $urandom_range(7, 0);
        d.valid = ($urandom_range(7, 0) != 0);
        d.pc = $urandom;
        d.rdst = 5'($urandom);
        d.ctl.memToReg = (op == 1);
        d.ctl.memWrite = (op == 2);
        d.ctl.regWrite = (op == 1) || (op == 0 && $urandom_range(1, 0) == 1);
        d.ctl.loWrite = 1'($urandom);
        d.ctl.hiWrite = 1'($urandom);
        d.ctl.cp0Write = 1'($urandom);
        d.ctl.loadUnsigned = 1'($urandom);
        d.ctl.msize = msize_e'($urandom_range(2, 0));
        case ($urandom_range(2, 0))
            0: d.aluOut = {1'b0, 31'($urandom)};
            1: d.aluOut = {3'b100, 29'($urandom)};
            default: d.aluOut = {3'b101, 29'($urandom)};
        endcase
        d.srcb = $urandom;
        d.cp0Ctl.isSlot = 1'($urandom);
        if (ev < 3) begin
            d.cp0Ctl.valid = 1'b1;
            d.cp0Ctl.ctype = (ev == 0) ? EXCEPTION : (ev == 1) ? INTERRUPT : ERET;
            d.cp0Ctl.code = 5'($urandom);
        end
        return d;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        int seedVal;
        rstN = 1'b0;
        dataE[0] = '0;
        dataE[1] = '0;
        dresp = '0;
        running = 1'b0;
        bundleCount = 0;
        waitLeft = 0;
        seedVal = $urandom(32'had324fd8);
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        running <= 1'b1;
        wait (bundleCount == NUM_BUNDLES);
        do @(posedge clk); while (stallM);
        // let the last load comparison run
        repeat (2) @(posedge clk);
        if (UUT.uChk.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "assertion failures were recorded");
        end
    end

    // new bundle whenever the stage is not stalled
    always @(posedge clk) begin
        if (running && !stallM) begin
            if (bundleCount < NUM_BUNDLES) begin
                dataE[1] <= randomLane();
                dataE[0] <= randomLane();
                bundleCount <= bundleCount + 1;
            end else begin
                dataE[0] <= '0;
                dataE[1] <= '0;
            end
        end
    end

    // bus responder with 0 to 3 wait cycles before dataOk
    always @(posedge clk) begin
        if (!rstN) begin
            dresp <= '0;
            waitLeft <= $urandom_range(3, 0);
        end else if (dresp.dataOk) begin
            dresp.dataOk <= 1'b0;
        end else if (dreq.valid) begin
            if (waitLeft == 0) begin
                dresp.dataOk <= 1'b1;
                dresp.data <= dreq.addr ^ RESP_KEY;
                waitLeft <= $urandom_range(3, 0);
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: bundles did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // first assertion failure ends the run
    always @(posedge clk) begin
        if (UUT.uChk.failCount > 0) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, UUT.uChk.failSig,
                UUT.uChk.failExp, UUT.uChk.failGot);
            $display("TEST FAILED");
            $fatal(1, "assertion failed");
        end
    end

endmodule

//--- testbench/memStage_assert.sv
`include "mem_config.svh"

module memStageAssert import memPkg::*; (
    input logic      clk,
    input logic      rstN,
    input exData_t   dataE[2],
    input exData_t   dataM[2],
    input word_t     loadData[2],
    input dbusReq_t  dreq,
    input dbusResp_t dresp,
    input logic      stallM,
    input logic      excpM
);
    timeunit 1ns;
    timeprecision 1ps;

    // failure hook read by the testbench
    int    failCount = 0;
    string failSig = "";
    word_t failExp;
    word_t failGot;

    logic [1:0] misExp;
    logic [1:0] goExp;
    logic       squashExp;
    logic       firstDone;
    logic       lane;
    exData_t    cur;
    logic       chkLoad;
    logic       chkLane;
    word_t      chkVal;

    function automatic word_t mapAddr(word_t v);
        return (v[31:30] == 2'b10) ? {3'b000, v[28:0]} : v;
    endfunction

    function automatic logic misRule(msize_e s, logic [1:0] low);
        if (s == MSIZE1) return 1'b0;
        if (s == MSIZE2) return low[0];
        return low != 2'b00;
    endfunction

    function automatic logic [3:0] strobeRule(msize_e s, logic [1:0] low);
        if (misRule(s, low)) return 4'b0000;
        if (s == MSIZE1) return 4'b0001 << low;
        if (s == MSIZE2) return low[1] ? 4'b1100 : 4'b0011;
        return 4'b1111;
    endfunction

    function automatic word_t dataRule(msize_e s, word_t b);
        if (s == MSIZE1) return {b[7:0], b[7:0], b[7:0], b[7:0]};
        if (s == MSIZE2) return {b[15:0], b[15:0]};
        return b;
    endfunction

    function automatic word_t extendRule(msize_e s, logic [1:0] low, logic u, word_t w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*low +: 8];
        h = w[16*low[1] +: 16];
        if (s == MSIZE1) return u ? {24'd0, b} : {{24{b[7]}}, b};
        if (s == MSIZE2) return u ? {16'd0, h} : {{16{h[15]}}, h};
        return w;
    endfunction

    function automatic logic trap(ctype_e t);
        return t == EXCEPTION || t == ERET;
    endfunction

    function automatic logic excOk(exData_t e, exData_t m);
        return m.cp0Ctl.ctype == EXCEPTION && m.cp0Ctl.badVaddr == e.aluOut &&
            m.cp0Ctl.code == (e.ctl.memWrite ? `EXC_ADES : `EXC_ADEL);
    endfunction

    task automatic noteFail(string s, word_t e, word_t g);
        failCount++;
        failSig = s;
        failExp = e;
        failGot = g;
    endtask

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            misExp[i] = dataE[i].valid && (dataE[i].ctl.memWrite || dataE[i].ctl.memToReg)
                && misRule(dataE[i].ctl.msize, dataE[i].aluOut[1:0]);
            goExp[i] = dataE[i].valid && (dataE[i].ctl.memWrite || dataE[i].ctl.memToReg)
                && !misExp[i] && !trap(dataE[i].cp0Ctl.ctype);
        end
        squashExp = trap(dataE[1].cp0Ctl.ctype) || misExp[1];
        goExp[0]  = goExp[0] && !squashExp;
        // older lane first until its data comes back
        lane = goExp[1] && !firstDone;
        cur  = dataE[lane];
    end

    always_ff @(posedge clk) begin
        if (!rstN || !stallM) begin
            firstDone <= 1'b0;
        end else if (dreq.valid && dresp.dataOk && lane) begin
            firstDone <= 1'b1;
        end
    end

    // load result is compared one cycle after its dataOk
    always_ff @(posedge clk) begin
        if (!rstN) begin
            chkLoad <= 1'b0;
        end else begin
            chkLoad <= dreq.valid && dresp.dataOk && cur.ctl.memToReg;
            chkLane <= lane;
            chkVal  <= extendRule(cur.ctl.msize, cur.aluOut[1:0], cur.ctl.loadUnsigned,
                dresp.data);
        end
    end

    aReset: assert property (@(posedge clk) !rstN |=> !dreq.valid && !stallM)
        else begin
            noteFail("dreq.valid", 0, 32'($sampled(dreq.valid)));
            $error("request or stall active right after reset");
        end

    aIdle: assert property (@(posedge clk) disable iff (!rstN) goExp == 2'b00 |-> !stallM)
        else begin
            noteFail("stallM", 0, 32'($sampled(stallM)));
            $error("stall with no lane going");
        end

    aGo: assert property (@(posedge clk) disable iff (!rstN) dreq.valid |-> goExp[lane])
        else begin
            noteFail("dreq.valid", 0, 32'($sampled(dreq.valid)));
            $error("request from a lane that must not go");
        end

    aAddr: assert property (@(posedge clk) disable iff (!rstN)
        dreq.valid |-> dreq.addr == mapAddr(cur.aluOut) &&
            dreq.uncached == (cur.aluOut[31:29] == 3'b101))
        else begin
            noteFail("dreq.addr", $sampled(mapAddr(cur.aluOut)), $sampled(dreq.addr));
            $error("translated address or uncached flag wrong");
        end

    aStrobe: assert property (@(posedge clk) disable iff (!rstN)
        dreq.valid |-> dreq.strobe == (cur.ctl.memWrite ?
            strobeRule(cur.ctl.msize, cur.aluOut[1:0]) : 4'b0000))
        else begin
            noteFail("dreq.strobe", 32'($sampled(strobeRule(cur.ctl.msize, cur.aluOut[1:0]))),
                32'($sampled(dreq.strobe)));
            $error("store strobe wrong");
        end

    aData: assert property (@(posedge clk) disable iff (!rstN)
        dreq.valid && cur.ctl.memWrite |-> dreq.data == dataRule(cur.ctl.msize, cur.srcb))
        else begin
            noteFail("dreq.data", $sampled(dataRule(cur.ctl.msize, cur.srcb)),
                $sampled(dreq.data));
            $error("store data wrong");
        end

    aHold: assert property (@(posedge clk) disable iff (!rstN)
        dreq.valid && !dresp.dataOk |=> dreq.valid && $stable(dreq))
        else begin
            noteFail("dreq.addr", $past(dreq.addr), $sampled(dreq.addr));
            $error("request changed before dataOk");
        end

    aLoad: assert property (@(posedge clk) disable iff (!rstN)
        chkLoad |-> loadData[chkLane] == chkVal)
        else begin
            noteFail("loadData", $sampled(chkVal), $sampled(loadData[chkLane]));
            $error("extended load data wrong");
        end

    aExc1: assert property (@(posedge clk) disable iff (!rstN)
        misExp[1] |-> excOk(dataE[1], dataM[1]))
        else begin
            noteFail("dataM[1].cp0Ctl.code",
                32'($sampled(dataE[1].ctl.memWrite) ? `EXC_ADES : `EXC_ADEL),
                32'($sampled(dataM[1].cp0Ctl.code)));
            $error("lane 1 address error not raised");
        end

    aExc0: assert property (@(posedge clk) disable iff (!rstN)
        misExp[0] && !squashExp |-> excOk(dataE[0], dataM[0]))
        else begin
            noteFail("dataM[0].cp0Ctl.code",
                32'($sampled(dataE[0].ctl.memWrite) ? `EXC_ADES : `EXC_ADEL),
                32'($sampled(dataM[0].cp0Ctl.code)));
            $error("lane 0 address error not raised");
        end

    aSquash: assert property (@(posedge clk) disable iff (!rstN)
        squashExp |-> !dataM[0].ctl.regWrite && !dataM[0].ctl.memToReg &&
            !dataM[0].ctl.loWrite && !dataM[0].ctl.hiWrite &&
            !dataM[0].ctl.cp0Write && !dataM[0].cp0Ctl.valid)
        else begin
            noteFail("dataM[0].ctl", 0, 32'($sampled(dataM[0].ctl)));
            $error("younger lane not squashed");
        end

    aExcp: assert property (@(posedge clk) disable iff (!rstN)
        excpM == (dataE[1].cp0Ctl.ctype != NOEVENT || dataE[0].cp0Ctl.ctype != NOEVENT ||
            misExp != 2'b00))
        else begin
            noteFail("excpM", 32'(!$sampled(excpM)), 32'($sampled(excpM)));
            $error("exception flag wrong");
        end

endmodule

bind memStage memStageAssert uChk (
    .clk      (clk),
    .rstN     (rstN),
    .dataE    (dataE),
    .dataM    (dataM),
    .loadData (loadData),
    .dreq     (dreq),
    .dresp    (dresp),
    .stallM   (stallM),
    .excpM    (excpM)
);
